// File: common/fb_wr_macros.svh
`ifndef FB_WR_MACROS_SVH
`define FB_WR_MACROS_SVH

//------------------------------
// Burst and front FIFO sizing
//------------------------------
`define FB_BURST_WORDS	64		// Full MCB burst, 32-bit words
`define FB_FIFO_DEPTH	256		// Front FIFO words
`define FB_FIFO_AW		8		// log2 of FIFO depth
`define FB_PE_THRESH	64		// Prog empty while fewer words than this
`define FB_FLUSH_CYC	4		// Flush pulse length, clk_vin cycles

//------------------------------
// Frame slot addressing
//------------------------------
`define FB_ADDR_W		17		// Burst address inside one slot

// MCB instruction codes
`define FB_CMD_WR		3'b000	// Plain write
`define FB_CMD_WR_PRE	3'b010	// Write with auto precharge

`endif

// File: common/fb_wr_pkg.sv
`default_nettype none

`include "fb_wr_macros.svh"

package fb_wr_pkg;

	// Frame slot number, up to 4 slots
	typedef logic [1:0] frame_slot_t;

	//------------------------------
	// MCB byte address, 1Gb part
	//------------------------------
	typedef union packed {
		logic [29:0]				flat;			// As sent on the cmd port
		struct packed {
			logic [2:0]				rsvd;			// Always zero for 1Gb
			frame_slot_t			slot;			// Frame slot
			logic [`FB_ADDR_W-1:0]	burst_addr;		// Burst index in slot
			logic [7:0]				byte_off;		// 64 words x 4 bytes, zero
		} fields;
	} mcb_byte_addr_u;

endpackage

`default_nettype wire

// File: common/front_buf_if.sv
`timescale 1ns/1ps
`default_nettype none

// Front FIFO read port, clk domain
interface front_buf_if;

	logic			rd_en;			// Read strobe from controller
	logic [35:0]	dout;			// Valid one clk after rd_en
	logic			empty;			// No word readable
	logic			prog_empty;		// Fewer than a burst of words

	// FIFO end
	modport fifo_side (
		input	rd_en,
		output	dout,
		output	empty,
		output	prog_empty
	);

	// Burst controller end
	modport ctrl_side (
		output	rd_en,
		input	dout,
		input	empty,
		input	prog_empty
	);

endinterface

`default_nettype wire

// File: front_buf/front_buf_flush.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_wr_macros.svh"

// Front FIFO flush at each frame start, video clock
module front_buf_flush (
	input	wire		clk_vin,
	input	wire		i_fval,			// Frame valid, high active
	output	logic		o_flush			// Clears the front FIFO
);

	logic			fval_dly = 1'b0;	// Previous i_fval
	logic [2:0]		flush_cnt = 3'd0;	// Remaining flush cycles

	//------------------------------
	// Rising edge of frame valid
	//------------------------------
	always @(posedge clk_vin) begin
		fval_dly <= i_fval;
		if (i_fval && !fval_dly) begin
			flush_cnt <= 3'(`FB_FLUSH_CYC);			// Restart pulse
		end else if (flush_cnt != 3'd0) begin
			flush_cnt <= flush_cnt - 3'd1;			// Count out
		end
	end

	assign o_flush = (flush_cnt != 3'd0);			// High for FB_FLUSH_CYC cycles

endmodule

`default_nettype wire

// File: front_buf/front_buf_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_wr_macros.svh"

// Dual clock FIFO 36 x 256, gray pointers
module front_buf_fifo (
	input	wire			clk_vin,
	input	wire			i_flush,		// Video domain clear
	input	wire			i_wr_en,
	input	wire [35:0]		iv_din,
	output	logic			o_full,			// Words dropped while high
	input	wire			clk,
	front_buf_if.fifo_side	rd_port
);

	localparam int				AW			= `FB_FIFO_AW;
	localparam logic [AW:0]		PE_THRESH	= (AW+1)'(`FB_PE_THRESH);

	logic [35:0]	mem [0:`FB_FIFO_DEPTH-1];	// Storage, no reset
	logic [AW:0]	rgray = '0;					// Read pointer, gray, clk domain

	//------------------------------
	// Write side, clk_vin
	//------------------------------
	logic [AW:0]	wbin = '0;
	logic [AW:0]	wgray = '0;
	logic [AW:0]	rgray_s1 = '0;				// Read pointer sync
	logic [AW:0]	rgray_s2 = '0;
	logic [AW:0]	wbin_nxt;
	logic			wr_ok;

	assign o_full	= i_flush |
		(wgray == {~rgray_s2[AW:AW-1], rgray_s2[AW-2:0]});	// Wrapped once
	assign wr_ok	= i_wr_en & ~o_full;
	assign wbin_nxt	= wbin + {{AW{1'b0}}, wr_ok};

	always @(posedge clk_vin) begin
		if (i_flush) begin						// Restart empty
			wbin		<= '0;
			wgray		<= '0;
			rgray_s1	<= '0;
			rgray_s2	<= '0;
		end else begin
			wbin		<= wbin_nxt;
			wgray		<= wbin_nxt ^ (wbin_nxt >> 1);
			rgray_s1	<= rgray;
			rgray_s2	<= rgray_s1;
		end
	end

	always @(posedge clk_vin) begin
		if (wr_ok) mem[wbin[AW-1:0]] <= iv_din;
	end

	//------------------------------
	// Read side, clk
	//------------------------------
	logic [AW:0]	rbin = '0;
	logic [AW:0]	wgray_s1 = '0;				// Write pointer sync
	logic [AW:0]	wgray_s2 = '0;
	logic [AW:0]	wbin_s;						// Decoded write pointer
	logic [AW:0]	rbin_nxt;
	logic [AW:0]	level;						// Words readable
	logic [1:0]		flush_sync = 2'b00;			// Flush into clk
	logic			rd_flush;
	logic			rd_ok;

	assign rd_flush	= flush_sync[1];
	assign rd_ok	= rd_port.rd_en & ~rd_port.empty;
	assign rbin_nxt	= rbin + {{AW{1'b0}}, rd_ok};

	always_comb begin							// Gray to binary
		wbin_s[AW] = wgray_s2[AW];
		for (int i = AW - 1; i >= 0; i--) begin
			wbin_s[i] = wbin_s[i+1] ^ wgray_s2[i];
		end
	end

	assign level				= wbin_s - rbin;
	assign rd_port.empty		= rd_flush | (rgray == wgray_s2);
	assign rd_port.prog_empty	= rd_flush | (level < PE_THRESH);

	always @(posedge clk) begin
		flush_sync <= {flush_sync[0], i_flush};
		if (rd_flush) begin
			rbin		<= '0;
			rgray		<= '0;
			wgray_s1	<= '0;
			wgray_s2	<= '0;
		end else begin
			rbin		<= rbin_nxt;
			rgray		<= rbin_nxt ^ (rbin_nxt >> 1);
			wgray_s1	<= wgray;
			wgray_s2	<= wgray_s1;
		end
	end

	always @(posedge clk) begin
		if (rd_ok) rd_port.dout <= mem[rbin[AW-1:0]];	// One cycle latency
	end

endmodule

`default_nettype wire

// File: wr_logic/wr_frame_ptr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_wr_macros.svh"

// Frame slot choice, arbiter handshake, burst address
module wr_frame_ptr import fb_wr_pkg::*; (
	input	wire					clk,
	input	wire					i_reset,
	input	wire					i_fval,				// Video domain level
	input	wire					i_frame_en,
	input	wire					i_calib_done,
	input	wire [2:0]				iv_frame_depth,		// 1, 2 or 4
	input	wire frame_slot_t		iv_rd_frame_ptr,	// Slot of reader
	input	wire					i_reading,
	output	logic					o_wr_req,
	input	wire					i_wr_ack,
	input	wire					i_burst_done,
	input	wire					i_fifo_drained,
	output	frame_slot_t			ov_wr_frame_ptr,
	output	logic [`FB_ADDR_W-1:0]	ov_wr_addr,
	output	logic					o_writing,
	output	logic					o_frame_end			// One clk pulse
);

	logic [1:0]		fval_sync;			// Two flop sync
	logic			fval_dly;
	logic			fval_rise;
	logic			fval_fall;
	logic			ack;
	logic [1:0]		slot_mask;			// Depth minus one
	frame_slot_t	slot_inc;
	frame_slot_t	slot_next;

	assign fval_rise	= fval_sync[1] & ~fval_dly;
	assign fval_fall	= ~fval_sync[1] & fval_dly;
	assign ack			= o_wr_req & i_wr_ack;

	//------------------------------
	// Next slot, modulo depth
	//------------------------------
	always_comb begin
		case (iv_frame_depth)
			3'd4:		slot_mask = 2'b11;
			3'd2:		slot_mask = 2'b01;
			default:	slot_mask = 2'b00;		// Single slot
		endcase
		slot_inc = (ov_wr_frame_ptr + 2'd1) & slot_mask;
		if (slot_mask == 2'b00) slot_next = 2'd0;
		else if (i_reading && slot_inc == iv_rd_frame_ptr) slot_next = ov_wr_frame_ptr;	// Reader busy there
		else slot_next = slot_inc;
	end

	always @(posedge clk) begin
		if (i_reset) begin
			fval_sync		<= 2'b00;
			fval_dly		<= 1'b0;
			o_wr_req		<= 1'b0;
			ov_wr_frame_ptr	<= 2'd0;
			ov_wr_addr		<= '0;
			o_writing		<= 1'b0;
			o_frame_end		<= 1'b0;
		end else begin
			fval_sync	<= {fval_sync[0], i_fval};
			fval_dly	<= fval_sync[1];
			o_frame_end	<= fval_fall;
			if (fval_rise && i_frame_en && i_calib_done) o_wr_req <= 1'b1;
			else if (ack) o_wr_req <= 1'b0;			// Drop after ack
			if (ack) ov_wr_frame_ptr <= slot_next;
			if (fval_rise) ov_wr_addr <= '0;			// New frame from burst 0
			else if (i_burst_done) ov_wr_addr <= ov_wr_addr + 1'b1;
			if (ack) o_writing <= 1'b1;
			else if (i_fifo_drained) o_writing <= 1'b0;	// Tail written
		end
	end

endmodule

`default_nettype wire

// File: wr_logic/wr_burst_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_wr_macros.svh"

// Moves front FIFO words into MCB port 2 in bursts
module wr_burst_ctrl import fb_wr_pkg::*; #(
	parameter bit P_WR_WITH_PRE = 1'b0				// Write with auto precharge
) (
	input	wire					clk,
	input	wire					i_reset,
	front_buf_if.ctrl_side			rd_port,
	input	wire					i_writing,			// Frame accepted
	input	wire					i_frame_end,
	input	wire frame_slot_t		iv_slot,
	input	wire [`FB_ADDR_W-1:0]	iv_addr,
	output	logic					o_burst_done,		// Command accepted
	output	logic					o_fifo_drained,		// Frame tail written
	output	logic					o_p2_wr_en,
	output	logic [31:0]			ov_p2_wr_data,
	input	wire					i_p2_wr_full,
	output	logic					o_p2_cmd_en,
	output	logic [2:0]				ov_p2_cmd_instr,
	output	logic [5:0]				ov_p2_cmd_bl,
	output	logic [29:0]			ov_p2_cmd_byte_addr,
	input	wire					i_p2_cmd_full
);

	localparam logic [1:0]	S_IDLE		= 2'd0;
	localparam logic [1:0]	S_MOVE		= 2'd1;		// Words to MCB
	localparam logic [1:0]	S_CMD		= 2'd2;		// Burst command
	localparam logic [1:0]	S_DRAIN		= 2'd3;		// Discard, frame not ours
	localparam logic [6:0]	BURST_WORDS	= 7'(`FB_BURST_WORDS);

	logic [1:0]		state;
	logic [6:0]		word_cnt;		// Words read this burst
	logic			word_vld;		// dout holds an unwritten word
	logic			tail;			// Frame end seen, flush remainder
	logic			wr_fire;
	logic			move_rd;
	logic			drain_rd;
	logic			move_end;
	logic			cmd_fire;
	logic			burst_start;
	logic [6:0]		cnt_m1;
	mcb_byte_addr_u	cmd_addr;

	//------------------------------
	// Read and write strobes
	//------------------------------
	assign wr_fire	= (state == S_MOVE) & word_vld & ~i_p2_wr_full;
	assign move_rd	= (state == S_MOVE) & ~rd_port.empty &
		(word_cnt != BURST_WORDS) & (~word_vld | wr_fire);	// Keep one word in flight
	assign drain_rd	= (state == S_DRAIN) & ~rd_port.empty;
	assign rd_port.rd_en = move_rd | drain_rd;

	// Burst over once every read word went out
	assign move_end	= ~word_vld & ((word_cnt == BURST_WORDS) | (tail & rd_port.empty));
	assign cmd_fire	= (state == S_CMD) & ~i_p2_cmd_full;
	assign burst_start = ~rd_port.empty & (~rd_port.prog_empty | tail);

	assign o_p2_wr_en		= wr_fire;
	assign ov_p2_wr_data	= rd_port.dout[31:0];		// Top nibble unused
	assign o_p2_cmd_en		= cmd_fire;
	assign o_burst_done		= cmd_fire;

	//------------------------------
	// Command fields
	//------------------------------
	assign cnt_m1			= word_cnt - 7'd1;
	assign ov_p2_cmd_bl		= cnt_m1[5:0];				// bl is words minus one
	assign ov_p2_cmd_instr	= P_WR_WITH_PRE ? `FB_CMD_WR_PRE : `FB_CMD_WR;

	always_comb begin
		cmd_addr.fields.rsvd		= 3'b000;			// 1Gb, upper bits zero
		cmd_addr.fields.slot		= iv_slot;
		cmd_addr.fields.burst_addr	= iv_addr;
		cmd_addr.fields.byte_off	= 8'h00;
	end
	assign ov_p2_cmd_byte_addr = cmd_addr.flat;

	//------------------------------
	// FSM
	//------------------------------
	always @(posedge clk) begin
		if (i_reset) begin
			state			<= S_IDLE;
			word_cnt		<= 7'd0;
			word_vld		<= 1'b0;
			tail			<= 1'b0;
			o_fifo_drained	<= 1'b0;
		end else begin
			o_fifo_drained	<= 1'b0;
			word_vld		<= move_rd | (word_vld & ~wr_fire);
			if (i_frame_end && i_writing) tail <= 1'b1;
			if (move_rd) word_cnt <= word_cnt + 7'd1;
			case (state)
				S_IDLE: begin
					word_cnt <= 7'd0;
					if (!i_writing) begin
						if (!rd_port.empty) state <= S_DRAIN;	// Stale or dropped frame
					end else if (burst_start) begin
						state <= S_MOVE;
					end else if (tail && rd_port.empty) begin
						o_fifo_drained	<= 1'b1;				// Frame complete
						tail			<= 1'b0;
					end
				end
				S_MOVE: begin
					if (move_end) state <= (word_cnt == 7'd0) ? S_IDLE : S_CMD;
				end
				S_CMD: begin
					if (cmd_fire) state <= S_IDLE;				// Hold while cmd FIFO full
				end
				default: begin
					if (i_writing || rd_port.empty) state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/frame_buffer_wr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_wr_macros.svh"

// Frame buffer write side, front FIFO and write logic
module frame_buffer_wr_top import fb_wr_pkg::*; #(
	parameter bit P_WR_WITH_PRE = 1'b0
) (
	// Video input, clk_vin
	input	wire					clk_vin,
	input	wire					i_fval,
	input	wire					i_dval,
	input	wire [31:0]				iv_image_din,
	output	logic					o_front_fifo_full,
	// Control
	input	wire					i_frame_en,
	input	wire [2:0]				iv_frame_depth,
	// Frame buffer domain
	input	wire					clk,
	input	wire					i_reset,
	output	frame_slot_t			ov_wr_frame_ptr,
	output	logic [`FB_ADDR_W-1:0]	ov_wr_addr,
	output	logic					o_wr_req,
	input	wire					i_wr_ack,
	output	logic					o_writing,
	input	wire frame_slot_t		iv_rd_frame_ptr,
	input	wire					i_reading,
	// MCB port 2
	input	wire					i_calib_done,
	output	logic					o_p2_cmd_en,
	output	logic [2:0]				ov_p2_cmd_instr,
	output	logic [5:0]				ov_p2_cmd_bl,
	output	logic [29:0]			ov_p2_cmd_byte_addr,
	input	wire					i_p2_cmd_full,
	output	logic					o_p2_wr_en,
	output	logic [31:0]			ov_p2_wr_data,
	input	wire					i_p2_wr_full
);

	logic	w_flush;				// Front FIFO clear
	logic	w_burst_done;
	logic	w_fifo_drained;
	logic	w_frame_end;

	front_buf_if front_buf_bus ();	// FIFO read port

	front_buf_flush front_buf_flush_inst (
		.clk_vin		(clk_vin			),
		.i_fval			(i_fval				),
		.o_flush		(w_flush			)
	);

	front_buf_fifo front_buf_fifo_inst (
		.clk_vin		(clk_vin				),
		.i_flush		(w_flush				),
		.i_wr_en		(i_dval					),
		.iv_din			({4'b0000, iv_image_din}),
		.o_full			(o_front_fifo_full		),
		.clk			(clk					),
		.rd_port		(front_buf_bus.fifo_side)
	);

	wr_frame_ptr wr_frame_ptr_inst (
		.clk				(clk				),
		.i_reset			(i_reset			),
		.i_fval				(i_fval				),
		.i_frame_en			(i_frame_en			),
		.i_calib_done		(i_calib_done		),
		.iv_frame_depth		(iv_frame_depth		),
		.iv_rd_frame_ptr	(iv_rd_frame_ptr	),
		.i_reading			(i_reading			),
		.o_wr_req			(o_wr_req			),
		.i_wr_ack			(i_wr_ack			),
		.i_burst_done		(w_burst_done		),
		.i_fifo_drained		(w_fifo_drained		),
		.ov_wr_frame_ptr	(ov_wr_frame_ptr	),
		.ov_wr_addr			(ov_wr_addr			),
		.o_writing			(o_writing			),
		.o_frame_end		(w_frame_end		)
	);

	wr_burst_ctrl #(
		.P_WR_WITH_PRE		(P_WR_WITH_PRE		)
	) wr_burst_ctrl_inst (
		.clk					(clk					),
		.i_reset				(i_reset				),
		.rd_port				(front_buf_bus.ctrl_side),
		.i_writing				(o_writing				),
		.i_frame_end			(w_frame_end			),
		.iv_slot				(ov_wr_frame_ptr		),
		.iv_addr				(ov_wr_addr				),
		.o_burst_done			(w_burst_done			),
		.o_fifo_drained			(w_fifo_drained			),
		.o_p2_wr_en				(o_p2_wr_en				),
		.ov_p2_wr_data			(ov_p2_wr_data			),
		.i_p2_wr_full			(i_p2_wr_full			),
		.o_p2_cmd_en			(o_p2_cmd_en			),
		.ov_p2_cmd_instr		(ov_p2_cmd_instr		),
		.ov_p2_cmd_bl			(ov_p2_cmd_bl			),
		.ov_p2_cmd_byte_addr	(ov_p2_cmd_byte_addr	),
		.i_p2_cmd_full			(i_p2_cmd_full			)
	);

endmodule

`default_nettype wire

// File: verif/frame_buffer_wr_chk.sv
`timescale 1ns/1ps
`default_nettype none

// MCB port 2 and arbiter handshake rules
module frame_buffer_wr_chk (
	input	wire		clk,
	input	wire		i_reset,
	input	wire		o_wr_req,
	input	wire		i_wr_ack,
	input	wire		o_p2_wr_en,
	input	wire		i_p2_wr_full,
	input	wire		o_p2_cmd_en,
	input	wire [5:0]	ov_p2_cmd_bl,
	input	wire		i_p2_cmd_full
);

	int			fail_cnt = 0;		// Failed assertions
	logic [6:0]	wr_words = 7'd0;	// Data words since the last command

	always @(posedge clk) begin
		if (i_reset || o_p2_cmd_en) wr_words <= 7'd0;
		else if (o_p2_wr_en) wr_words <= wr_words + 7'd1;
	end

	//------------------------------
	// MCB port 2
	//------------------------------
	wr_en_not_full: assert property (@(posedge clk) disable iff (i_reset)
		o_p2_wr_en |-> !i_p2_wr_full)
		else begin
			fail_cnt++;
			$error("Write strobe while the MCB write FIFO is full");
		end

	cmd_en_not_full: assert property (@(posedge clk) disable iff (i_reset)
		o_p2_cmd_en |-> !i_p2_cmd_full)
		else begin
			fail_cnt++;
			$error("Command strobe while the MCB command FIFO is full");
		end

	cmd_en_pulse: assert property (@(posedge clk) disable iff (i_reset)
		o_p2_cmd_en |=> !o_p2_cmd_en)		// One cycle per burst
		else begin
			fail_cnt++;
			$error("Command strobe longer than one cycle");
		end

	// Burst of 1 to 64 words, all written before its command
	bl_matches_words: assert property (@(posedge clk) disable iff (i_reset)
		o_p2_cmd_en |-> wr_words != 7'd0 && wr_words <= 7'd64 &&
			{1'b0, ov_p2_cmd_bl} == wr_words - 7'd1)
		else begin
			fail_cnt++;
			$error("Burst length does not match the words written before the command");
		end

	// Arbiter request drops right after ack
	req_falls_on_ack: assert property (@(posedge clk) disable iff (i_reset)
		o_wr_req && i_wr_ack |=> !o_wr_req)
		else begin
			fail_cnt++;
			$error("Write request still high after acknowledge");
		end

endmodule

bind frame_buffer_wr_top frame_buffer_wr_chk chk_inst (
	.clk			(clk			),
	.i_reset		(i_reset		),
	.o_wr_req		(o_wr_req		),
	.i_wr_ack		(i_wr_ack		),
	.o_p2_wr_en		(o_p2_wr_en		),
	.i_p2_wr_full	(i_p2_wr_full	),
	.o_p2_cmd_en	(o_p2_cmd_en	),
	.ov_p2_cmd_bl	(ov_p2_cmd_bl	),
	.i_p2_cmd_full	(i_p2_cmd_full	)
);

`default_nettype wire

// File: verif/tb_frame_buffer_wr.sv
`timescale 1ns/1ps
`default_nettype none

`include "fb_wr_macros.svh"

module tb_frame_buffer_wr import fb_wr_pkg::*; ();

	localparam int	TIMEOUT		= 4000;		// Cycles per wait
	localparam int	N_FRAMES	= 16;

	// One received MCB command
	typedef struct packed {
		mcb_byte_addr_u		addr;
		logic [5:0]			bl;
		logic [2:0]			instr;
		logic [7:0]			words;		// Data words since last command
	} cmd_rec_t;

	logic					clk = 1'b0;
	logic					clk_vin = 1'b0;
	logic					i_reset = 1'b1;
	logic					i_fval = 1'b0;
	logic					i_dval = 1'b0;
	logic [31:0]			iv_image_din = '0;
	logic					i_frame_en = 1'b0;
	logic [2:0]				iv_frame_depth = 3'd1;
	logic					i_wr_ack = 1'b0;
	frame_slot_t			iv_rd_frame_ptr = 2'd0;
	logic					i_reading = 1'b0;
	logic					i_calib_done = 1'b0;
	logic					i_p2_cmd_full = 1'b0;
	logic					i_p2_wr_full = 1'b0;
	logic					o_front_fifo_full;
	frame_slot_t			ov_wr_frame_ptr;
	logic [`FB_ADDR_W-1:0]	ov_wr_addr;
	logic					o_wr_req;
	logic					o_writing;
	logic					o_p2_cmd_en;
	logic [2:0]				ov_p2_cmd_instr;
	logic [5:0]				ov_p2_cmd_bl;
	logic [29:0]			ov_p2_cmd_byte_addr;
	logic					o_p2_wr_en;
	logic [31:0]			ov_p2_wr_data;

	integer					seed = 46;			// Frame and pixel stimulus
	integer					bp_seed = 46;		// MCB back-pressure
	int						mism_cnt = 0;
	int						err_cnt = 0;
	bit						timed_out = 1'b0;	// A wait gave up, run winds down
	logic [31:0]			exp_words[$];		// Pixels still due on MCB
	cmd_rec_t				cmd_q[$];
	int						burst_words = 0;
	bit						req_ok = 1'b0;		// Request allowed now
	frame_slot_t			model_slot = 2'd0;

	frame_buffer_wr_top dut (.*);

	always #50 clk = ~clk;
	always begin							// Video clock, skewed from clk
		#20 clk_vin = 1'b1;
		#50 clk_vin = 1'b0;
		#30;
	end

	always @(negedge clk) begin
		i_p2_wr_full	= ($random(bp_seed) % 8) == 0;
		i_p2_cmd_full	= ($random(bp_seed) % 4) == 0;
	end

	//------------------------------
	// MCB port model
	//------------------------------
	always @(posedge clk) begin
		cmd_rec_t rec;
		if (!i_reset) begin
			if (o_wr_req && !req_ok) begin
				err_cnt++;
				$display("Error at %0t: write request for a frame that must be dropped", $time);
			end
			if (o_p2_wr_en) begin
				if (exp_words.size() == 0) begin
					err_cnt++;
					$display("Error at %0t: data word written with none expected", $time);
				end else check_word(exp_words.pop_front(), ov_p2_wr_data);
				burst_words++;
			end
			if (o_p2_cmd_en) begin
				rec.addr.flat	= ov_p2_cmd_byte_addr;
				rec.bl			= ov_p2_cmd_bl;
				rec.instr		= ov_p2_cmd_instr;
				rec.words		= 8'(burst_words);
				cmd_q.push_back(rec);
				burst_words		= 0;
			end
		end
	end

	//------------------------------
	// Compare tasks
	//------------------------------
	task automatic check_word(input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			mism_cnt++;
			$display("Mismatch at %0t: data word %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_slot(input frame_slot_t exp, input frame_slot_t got);
		if (got !== exp) begin
			mism_cnt++;
			$display("Mismatch at %0t: frame slot %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_addr(input mcb_byte_addr_u exp, input mcb_byte_addr_u got);
		if (got.flat !== exp.flat) begin
			mism_cnt++;
			$display("Mismatch at %0t: address slot %0d burst %0d (%h), expected slot %0d burst %0d",
				$time, got.fields.slot, got.fields.burst_addr, got.flat,
				exp.fields.slot, exp.fields.burst_addr);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			mism_cnt++;
			$display("Mismatch at %0t: %s %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic end_run();
		int asrt;
		asrt = dut.chk_inst.fail_cnt;
		$display("Errors: %0d mismatch, %0d other, %0d assertion", mism_cnt, err_cnt, asrt);
		if (mism_cnt == 0 && err_cnt == 0 && asrt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	// Poll o_wr_req or o_writing on clk
	task automatic wait_level(input bit use_writing, input logic level);
		int n;
		n = 0;
		while (!timed_out && (use_writing ? o_writing : o_wr_req) !== level && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!timed_out && (use_writing ? o_writing : o_wr_req) !== level) begin
			err_cnt++;
			timed_out = 1'b1;
			$display("Error at %0t: timed out waiting for %s to become %b", $time,
				use_writing ? "o_writing" : "o_wr_req", level);
		end
	endtask

	// Slot rule: next modulo depth, skip onto the reader's slot
	function automatic frame_slot_t next_slot(input frame_slot_t cur, input int depth,
		input bit reading, input frame_slot_t rd);
		frame_slot_t n;
		if (depth == 1) return 2'd0;
		n = frame_slot_t'((int'(cur) + 1) % depth);
		if (reading && n == rd) return cur;
		return n;
	endfunction

	//------------------------------
	// Frame stimulus
	//------------------------------
	task automatic send_words(input int len, input bit keep);
		int				sent;
		int				n;
		logic [31:0]	w;
		sent = 0;
		n = 0;
		while (sent < len && !timed_out) begin
			@(negedge clk_vin);
			n++;
			check_value("front FIFO full", 0, o_front_fifo_full);	// Drain outruns pixels
			if (n > TIMEOUT) begin
				err_cnt++;
				timed_out = 1'b1;
				$display("Error at %0t: front FIFO stayed full, pixels not accepted", $time);
			end else if (!o_front_fifo_full && ($random(seed) & 1)) begin
				w				= $random(seed);
				i_dval			= 1'b1;
				iv_image_din	= w;
				if (keep) exp_words.push_back(w);
				sent++;
			end else begin
				i_dval = 1'b0;		// Gap
			end
		end
		@(negedge clk_vin);
		i_dval = 1'b0;
	endtask

	task automatic check_frame(input int len, input frame_slot_t slot);
		int				nb;
		int				words;
		cmd_rec_t		rec;
		mcb_byte_addr_u	exp_addr;
		nb = (len + `FB_BURST_WORDS - 1) / `FB_BURST_WORDS;
		check_value("commands in frame", nb, cmd_q.size());
		check_value("burst address after frame", nb, ov_wr_addr);	// One step per burst
		if (exp_words.size() != 0) begin
			err_cnt++;
			$display("Error at %0t: %0d pixel words never reached the MCB", $time, exp_words.size());
			exp_words.delete();
		end
		for (int k = 0; k < nb && cmd_q.size() > 0; k++) begin
			rec = cmd_q.pop_front();
			words = (k == nb - 1) ? len - (nb - 1) * `FB_BURST_WORDS : `FB_BURST_WORDS;
			check_value("burst words", words, rec.words);
			check_value("burst length", words - 1, rec.bl);
			check_value("instruction", `FB_CMD_WR, rec.instr);
			exp_addr.flat				= '0;
			exp_addr.fields.slot		= slot;
			exp_addr.fields.burst_addr	= 17'(k);		// Consecutive from 0
			check_addr(exp_addr, rec.addr);
		end
		cmd_q.delete();
	endtask

	task automatic run_frame();
		int				len;
		int				depth;
		bit				accept;
		frame_slot_t	exp_slot;
		len = 1 + ($unsigned($random(seed)) % 320);
		if (len % `FB_BURST_WORDS == 0) len = len + 1;
		depth = 1 << ($unsigned($random(seed)) % 3);
		exp_slot = model_slot;
		@(negedge clk);
		iv_frame_depth	= 3'(depth);
		i_frame_en		= ($random(seed) % 6) != 0;
		i_calib_done	= ($random(seed) % 8) != 0;
		i_reading		= (depth > 1) && (($random(seed) & 1) != 0);	// One slot, nothing to protect
		iv_rd_frame_ptr	= frame_slot_t'($random(seed));
		accept			= i_frame_en && i_calib_done;
		req_ok			= accept;
		@(negedge clk_vin);
		i_fval = 1'b1;
		if (accept) begin
			wait_level(1'b0, 1'b1);
			repeat ($unsigned($random(seed)) % 4) @(negedge clk);		// Arbiter latency
			exp_slot = next_slot(model_slot, depth, i_reading, iv_rd_frame_ptr);
			i_wr_ack = 1'b1;
			@(negedge clk);
			i_wr_ack = 1'b0;
			req_ok = 1'b0;
			wait_level(1'b1, 1'b1);
			if (!timed_out) begin
				check_slot(exp_slot, ov_wr_frame_ptr);
				if (i_reading && ov_wr_frame_ptr == iv_rd_frame_ptr) begin
					err_cnt++;
					$display("Error at %0t: slot %0d chosen while the reader uses it", $time,
						ov_wr_frame_ptr);
				end
			end
			model_slot = exp_slot;
		end
		repeat (8) @(negedge clk_vin);		// Flush over
		send_words(len, accept);
		repeat (4) @(negedge clk_vin);
		i_fval = 1'b0;
		if (accept) begin
			wait_level(1'b1, 1'b0);
			if (!timed_out) check_frame(len, exp_slot);
		end else begin
			repeat (40) @(negedge clk);		// Dropped words drain
			check_value("commands of dropped frame", 0, cmd_q.size());
			check_value("burst address of dropped frame", 0, ov_wr_addr);
			cmd_q.delete();
		end
		repeat (4) @(negedge clk);
	endtask

	initial begin
		repeat (8) @(negedge clk);
		check_value("o_wr_req after reset", 0, o_wr_req);
		check_value("o_writing after reset", 0, o_writing);
		check_value("o_p2_wr_en after reset", 0, o_p2_wr_en);
		check_value("o_p2_cmd_en after reset", 0, o_p2_cmd_en);
		check_slot(2'd0, ov_wr_frame_ptr);
		i_reset = 1'b0;
		repeat (N_FRAMES) begin
			if (!timed_out) run_frame();
		end
		repeat (10) @(negedge clk);
		end_run();
	end

endmodule

`default_nettype wire

// File: frame_buffer_wr.f
+incdir+common
common/fb_wr_pkg.sv
common/front_buf_if.sv
front_buf/front_buf_flush.sv
front_buf/front_buf_fifo.sv
wr_logic/wr_frame_ptr.sv
wr_logic/wr_burst_ctrl.sv
hdl/frame_buffer_wr_top.sv
verif/frame_buffer_wr_chk.sv
verif/tb_frame_buffer_wr.sv
